// ==== logic/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;

    // major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // LW and SW
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;

    // funct7 bit 30 picks SUB over ADD
    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_WB,
        FWD_MEM
    } fwd_sel_t;

    // write-back value
    typedef enum logic {
        RES_ALU,
        RES_MEM
    } result_src_t;

endpackage

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode
    import riscv_isa_pkg::*, pipe_pkg::*;
(
    input  instr_t      instr,
    output reg_addr_t   rs1,
    output reg_addr_t   rs2,
    output reg_addr_t   rd,
    output word_t       imm,
    output alu_op_t     alu_op,
    output logic        alu_src_imm,
    output logic        reg_write,
    output logic        mem_read,
    output logic        mem_write,
    output logic        branch,
    output result_src_t result_src
);
    opcode_t opcode;
    logic [2:0] funct3;
    logic uses_rs2;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // rs2 only matters for register, store and branch forms
    assign uses_rs2 = (opcode == OPC_OP) || (opcode == OPC_STORE) || (opcode == OPC_BRANCH);
    assign rs1 = instr[19:15];
    assign rs2 = uses_rs2 ? instr[24:20] : '0;
    assign rd  = instr[11:7];

    always_comb begin
        case (opcode)
            OPC_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                               instr[11:8], 1'b0};
            default:    imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        result_src  = RES_ALU;
        case (opcode)
            OPC_OP: begin
                reg_write = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = (instr[31:25] == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    reg_write = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                alu_src_imm = 1'b1;
                reg_write   = (funct3 == F3_ADD_SUB);
            end
            OPC_LOAD: begin
                alu_src_imm = 1'b1;
                reg_write   = (funct3 == F3_WORD);
                mem_read    = (funct3 == F3_WORD);
                result_src  = RES_MEM;
            end
            OPC_STORE: begin
                alu_src_imm = 1'b1;
                mem_write   = (funct3 == F3_WORD);
            end
            OPC_BRANCH: branch = (funct3 == F3_BEQ);
            default: ;
        endcase
    end
endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import pipe_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      we,
    input  word_t     wd,
    output word_t     rd1,
    output word_t     rd2
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // x0 reads zero, a same-cycle write is bypassed
    assign rd1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];
endmodule

// ==== logic/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage
    import pipe_pkg::*;
(
    input  word_t    rd1,
    input  word_t    rd2,
    input  word_t    imm,
    input  word_t    pc,
    input  word_t    mem_fwd,
    input  word_t    wb_fwd,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  alu_op_t  alu_op,
    input  logic     alu_src_imm,
    input  logic     branch,
    output word_t    alu_result,
    output word_t    write_data,
    output word_t    branch_target,
    output logic     branch_taken
);
    word_t src_a, src_b;

    function automatic word_t pick_operand(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                           word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a      = pick_operand(fwd_a, rd1, mem_fwd, wb_fwd);
    assign write_data = pick_operand(fwd_b, rd2, mem_fwd, wb_fwd);
    assign src_b      = alu_src_imm ? imm : write_data;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_result = src_a - src_b;
            ALU_AND: alu_result = src_a & src_b;
            ALU_OR:  alu_result = src_a | src_b;
            ALU_SLT: alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
            default: alu_result = src_a + src_b;
        endcase
    end

    // BEQ compares the forwarded register values
    assign branch_taken  = branch && (src_a == write_data);
    assign branch_target = pc + imm;
endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
    import pipe_pkg::*;
(
    input  reg_addr_t rs1_d,
    input  reg_addr_t rs2_d,
    input  reg_addr_t rs1_e,
    input  reg_addr_t rs2_e,
    input  reg_addr_t rd_e,
    input  reg_addr_t rd_m,
    input  reg_addr_t rd_w,
    input  logic      mem_read_e,
    input  logic      reg_write_m,
    input  logic      reg_write_w,
    input  logic      branch_taken,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b,
    output logic      stall_f,
    output logic      stall_d,
    output logic      flush_d,
    output logic      flush_e
);
    logic load_use;

    // memory stage is younger, so it wins
    function automatic fwd_sel_t fwd_select(reg_addr_t rs);
        if (rs == '0) begin
            return FWD_NONE;
        end else if (reg_write_m && rd_m == rs) begin
            return FWD_MEM;
        end else if (reg_write_w && rd_w == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a = fwd_select(rs1_e);
    assign fwd_b = fwd_select(rs2_e);

    assign load_use = mem_read_e && rd_e != '0 && (rd_e == rs1_d || rd_e == rs2_d);

    // hold fetch and decode, bubble into execute
    assign stall_f = load_use;
    assign stall_d = load_use;
    assign flush_d = branch_taken;
    assign flush_e = load_use || branch_taken;
endmodule

// ==== logic/riscv_pipeline.sv ====
`timescale 1ns/1ps

module riscv_pipeline
    import riscv_isa_pkg::*, pipe_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic   clk,
    input  logic   rst,
    output word_t  pc,
    input  instr_t instr,
    output word_t  data_addr,
    output word_t  din,
    output logic   data_we,
    output logic   data_re,
    input  word_t  read_data
);
    logic stall_f, stall_d, flush_d, flush_e;
    fwd_sel_t fwd_a, fwd_b;

    // fetch/decode register
    word_t  pc_d;
    instr_t instr_d;

    // decode outputs
    reg_addr_t rs1_d, rs2_d, rd_d;
    word_t imm_d, rd1_d, rd2_d;
    alu_op_t alu_op_d;
    logic alu_src_imm_d, reg_write_d, mem_read_d, mem_write_d, branch_d;
    result_src_t result_src_d;

    // decode/execute register
    word_t pc_e, rd1_e, rd2_e, imm_e;
    reg_addr_t rs1_e, rs2_e, rd_e;
    alu_op_t alu_op_e;
    logic alu_src_imm_e, reg_write_e, mem_read_e, mem_write_e, branch_e;
    result_src_t result_src_e;

    // execute outputs
    word_t alu_result_e, write_data_e, branch_target;
    logic branch_taken;

    // execute/memory register
    word_t alu_result_m, write_data_m;
    reg_addr_t rd_m;
    logic reg_write_m, mem_read_m, mem_write_m;
    result_src_t result_src_m;

    // memory/write-back register
    word_t alu_result_w, read_data_w, result_w;
    reg_addr_t rd_w;
    logic reg_write_w;
    result_src_t result_src_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!stall_f) begin
            pc <= branch_taken ? branch_target : pc + 32'd4;
        end
    end

    // a cleared instr decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            instr_d <= '0;
            pc_d    <= '0;
        end else if (!stall_d) begin
            instr_d <= instr;
            pc_d    <= pc;
        end
    end

    instr_decode instr_decode_inst (
        .instr(instr_d), .rs1(rs1_d), .rs2(rs2_d), .rd(rd_d), .imm(imm_d),
        .alu_op(alu_op_d), .alu_src_imm(alu_src_imm_d), .reg_write(reg_write_d),
        .mem_read(mem_read_d), .mem_write(mem_write_d), .branch(branch_d),
        .result_src(result_src_d)
    );

    reg_file reg_file_inst (
        .clk(clk), .rs1(rs1_d), .rs2(rs2_d), .rd(rd_w), .we(reg_write_w),
        .wd(result_w), .rd1(rd1_d), .rd2(rd2_d)
    );

    always_ff @(posedge clk) begin
        if (rst || flush_e) begin
            reg_write_e  <= 1'b0;
            mem_read_e   <= 1'b0;
            mem_write_e  <= 1'b0;
            branch_e     <= 1'b0;
            result_src_e <= RES_ALU;
        end else begin
            reg_write_e  <= reg_write_d;
            mem_read_e   <= mem_read_d;
            mem_write_e  <= mem_write_d;
            branch_e     <= branch_d;
            result_src_e <= result_src_d;
        end
    end

    always_ff @(posedge clk) begin
        pc_e          <= pc_d;
        rd1_e         <= rd1_d;
        rd2_e         <= rd2_d;
        imm_e         <= imm_d;
        rs1_e         <= rs1_d;
        rs2_e         <= rs2_d;
        rd_e          <= rd_d;
        alu_op_e      <= alu_op_d;
        alu_src_imm_e <= alu_src_imm_d;
    end

    exec_stage exec_stage_inst (
        .rd1(rd1_e), .rd2(rd2_e), .imm(imm_e), .pc(pc_e), .mem_fwd(alu_result_m),
        .wb_fwd(result_w), .fwd_a(fwd_a), .fwd_b(fwd_b), .alu_op(alu_op_e),
        .alu_src_imm(alu_src_imm_e), .branch(branch_e), .alu_result(alu_result_e),
        .write_data(write_data_e), .branch_target(branch_target),
        .branch_taken(branch_taken)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_m  <= 1'b0;
            mem_read_m   <= 1'b0;
            mem_write_m  <= 1'b0;
            result_src_m <= RES_ALU;
            reg_write_w  <= 1'b0;
            result_src_w <= RES_ALU;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_read_m   <= mem_read_e;
            mem_write_m  <= mem_write_e;
            result_src_m <= result_src_e;
            reg_write_w  <= reg_write_m;
            result_src_w <= result_src_m;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_m <= alu_result_e;
        write_data_m <= write_data_e;
        rd_m         <= rd_e;
        alu_result_w <= alu_result_m;
        read_data_w  <= read_data;
        rd_w         <= rd_m;
    end

    // data port straight from the memory-stage register
    assign data_addr = alu_result_m;
    assign din       = write_data_m;
    assign data_we   = mem_write_m;
    assign data_re   = mem_read_m;

    assign result_w = (result_src_w == RES_MEM) ? read_data_w : alu_result_w;

    hazard_unit hazard_unit_inst (
        .rs1_d(rs1_d), .rs2_d(rs2_d), .rs1_e(rs1_e), .rs2_e(rs2_e), .rd_e(rd_e),
        .rd_m(rd_m), .rd_w(rd_w), .mem_read_e(mem_read_e), .reg_write_m(reg_write_m),
        .reg_write_w(reg_write_w), .branch_taken(branch_taken), .fwd_a(fwd_a),
        .fwd_b(fwd_b), .stall_f(stall_f), .stall_d(stall_d), .flush_d(flush_d),
        .flush_e(flush_e)
    );
endmodule

// ==== verification/riscv_pipeline_chk.sv ====
`timescale 1ns/1ps

module riscv_pipeline_chk
    import pipe_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input word_t pc,
    input logic  data_we,
    input logic  stall_f,
    input logic  flush_e,
    input logic  reg_write_e
);
    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    no_store_in_reset: assert property (@(posedge clk) rst |=> !data_we)
        else $error("data_we high while in reset");

    stall_holds_pc: assert property (@(posedge clk) disable iff (rst) stall_f |=> pc == $past(pc))
        else $error("pc moved during a fetch stall");

    // bubble in execute must not write back
    flush_clears_write: assert property (@(posedge clk) disable iff (rst)
        flush_e |=> !reg_write_e)
        else $error("reg_write survived an execute flush");
endmodule

bind riscv_pipeline riscv_pipeline_chk riscv_pipeline_chk_inst (
    .clk(clk), .rst(rst), .pc(pc), .data_we(data_we), .stall_f(stall_f),
    .flush_e(flush_e), .reg_write_e(reg_write_e)
);

// ==== verification/riscv_pipeline_tb.sv ====
`timescale 1ns/1ps

module riscv_pipeline_tb
    import riscv_isa_pkg::*, pipe_pkg::*;
();
    localparam int NUM_TESTS = 8;
    localparam int PROG_LEN = 60;
    localparam int LAST_IDX = PROG_LEN - 1;
    localparam int CLK_NS = 4;
    localparam int WATCHDOG_NS = NUM_TESTS * (PROG_LEN * 3 * CLK_NS + 100);
    localparam logic [31:0] SEED = 32'h690d_25c4;
    localparam word_t RESET_PC = '0;

    // instruction kinds of the generator
    localparam int K_ADD = 0, K_SUB = 1, K_AND = 2, K_OR = 3, K_SLT = 4;
    localparam int K_ADDI = 5, K_LW = 6, K_SW = 7, K_BEQ = 8;

    logic clk, rst, data_we, data_re;
    word_t pc, data_addr, din, read_data;
    instr_t instr;

    instr_t prog [64];
    word_t dmem [64];
    int kind [PROG_LEN];
    reg_addr_t rd_a [PROG_LEN];
    reg_addr_t rs1_a [PROG_LEN];
    reg_addr_t rs2_a [PROG_LEN];
    word_t imm_a [PROG_LEN];

    word_t exp_addr [$];
    word_t exp_data [$];
    word_t exp_load [$];
    int model_stores, stores_seen, errors, failed_tests;
    int model_loads, loads_seen;
    string test_name = "reset";

    riscv_pipeline #(.RESET_PC(RESET_PC)) riscv_pipeline_inst (
        .clk(clk), .rst(rst), .pc(pc), .instr(instr), .data_addr(data_addr),
        .din(din), .data_we(data_we), .data_re(data_re), .read_data(read_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(string name, int expected, int actual);
        if (actual != expected) begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    function automatic word_t fill_word(int idx);
        word_t addr;
        addr = word_t'(idx * 4);
        return (addr << 20) ^ (addr * 32'h0001_0103) ^ 32'h5a5a_0000;
    endfunction

    function automatic reg_addr_t pick_reg();
        return reg_addr_t'($urandom % 9);
    endfunction

    function automatic instr_t encode(int k, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                                      word_t imm);
        case (k)
            K_ADD:   return {7'b0, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
            K_SUB:   return {F7_SUB, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
            K_AND:   return {7'b0, rs2, rs1, F3_AND, rd, OPC_OP};
            K_OR:    return {7'b0, rs2, rs1, F3_OR, rd, OPC_OP};
            K_SLT:   return {7'b0, rs2, rs1, F3_SLT, rd, OPC_OP};
            K_ADDI:  return {imm[11:0], rs1, F3_ADD_SUB, rd, OPC_OP_IMM};
            K_LW:    return {imm[11:0], rs1, F3_WORD, rd, OPC_LOAD};
            K_SW:    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
            default: return {imm[12], imm[10:5], rs2, rs1, F3_BEQ, imm[4:1], imm[11], OPC_BRANCH};
        endcase
    endfunction

    task automatic build_program();
        word_t r;
        int k;
        for (int i = 0; i < PROG_LEN; i++) begin
            r = $urandom;
            rd_a[i] = pick_reg();
            rs1_a[i] = pick_reg();
            rs2_a[i] = pick_reg();
            imm_a[i] = {{20{r[11]}}, r[11:0]};
            if (i < 8) begin
                // seed x1..x8
                k = K_ADDI;
                rd_a[i] = reg_addr_t'(i + 1);
                rs1_a[i] = '0;
            end else if (i == LAST_IDX) begin
                k = K_BEQ;
                rs1_a[i] = '0;
                rs2_a[i] = '0;
                imm_a[i] = '0;
            end else begin
                k = int'($urandom % 9);
                // no branch may land past the closing loop
                if (k == K_BEQ && i > LAST_IDX - 3) begin
                    k = K_ADDI;
                end
                if (k == K_LW || k == K_SW) begin
                    rs1_a[i] = '0;
                    imm_a[i] = {24'b0, r[5:0], 2'b00};
                end
                if (k == K_BEQ) begin
                    imm_a[i] = r[12] ? 32'd12 : 32'd8;
                    if (r[13]) begin
                        rs2_a[i] = rs1_a[i];
                    end
                end
            end
            kind[i] = k;
            prog[i] = encode(k, rd_a[i], rs1_a[i], rs2_a[i], imm_a[i]);
        end
        for (int i = PROG_LEN; i < 64; i++) begin
            prog[i] = '0;
        end
    endtask

    // instruction-set model stepping one instruction at a time
    task automatic run_model();
        word_t regs [32];
        word_t mem [64];
        word_t a, b, addr, res;
        int i;
        for (int j = 0; j < 32; j++) begin
            regs[j] = '0;
        end
        for (int j = 0; j < 64; j++) begin
            mem[j] = fill_word(j);
        end
        exp_addr.delete();
        exp_data.delete();
        exp_load.delete();
        i = 0;
        while (i < LAST_IDX) begin
            a = regs[rs1_a[i]];
            b = regs[rs2_a[i]];
            addr = a + imm_a[i];
            res = '0;
            case (kind[i])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI: res = addr;
                K_LW: begin
                    res = mem[addr[7:2]];
                    exp_load.push_back(addr);
                end
                K_SW: begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    mem[addr[7:2]] = b;
                end
                default: ;
            endcase
            if (kind[i] != K_SW && kind[i] != K_BEQ && rd_a[i] != '0) begin
                regs[rd_a[i]] = res;
            end
            if (kind[i] == K_BEQ && a == b) begin
                i += int'(imm_a[i]) / 4;
            end else begin
                i++;
            end
        end
        model_stores = exp_addr.size();
        model_loads = exp_load.size();
    endtask

    // check and apply stores and loads before driving both read ports
    always @(negedge clk) begin
        if (data_we === 1'b1) begin
            stores_seen++;
            if (exp_addr.size() == 0) begin
                $display("%s: store to %h that the model never made", test_name, data_addr);
                errors++;
            end else begin
                check_word({test_name, " store addr"}, exp_addr.pop_front(), data_addr);
                check_word({test_name, " store data"}, exp_data.pop_front(), din);
            end
            if (data_addr[31:8] == '0) begin
                dmem[data_addr[7:2]] = din;
            end
        end
        if (data_re === 1'b1) begin
            loads_seen++;
            if (exp_load.size() == 0) begin
                $display("%s: load from %h that the model never made", test_name, data_addr);
                errors++;
            end else begin
                check_word({test_name, " load addr"}, exp_load.pop_front(), data_addr);
            end
        end
        instr = (pc[31:8] == '0) ? prog[pc[7:2]] : '0;
        read_data = (data_addr[31:8] == '0) ? dmem[data_addr[7:2]] : '0;
    end

    initial begin
        int cycles;
        int errors_before;
        rst = 1'b1;
        instr = '0;
        read_data = '0;
        errors = 0;
        failed_tests = 0;
        stores_seen = 0;
        loads_seen = 0;
        void'($urandom(SEED));
        for (int t = 0; t < NUM_TESTS; t++) begin
            // rst is already high for the first test
            if (t > 0) begin
                @(negedge clk);
            end
            rst = 1'b1;
            test_name = $sformatf("prog_%0d", t);
            errors_before = errors;
            build_program();
            run_model();
            for (int j = 0; j < 64; j++) begin
                dmem[j] = fill_word(j);
            end
            stores_seen = 0;
            loads_seen = 0;
            repeat (4) @(negedge clk);
            check_word({test_name, " reset pc"}, RESET_PC, pc);
            rst = 1'b0;
            cycles = 0;
            while (pc !== word_t'(LAST_IDX * 4) && cycles < PROG_LEN * 3) begin
                @(negedge clk);
                cycles++;
            end
            if (pc !== word_t'(LAST_IDX * 4)) begin
                $display("%s: pc never reached the closing branch", test_name);
                errors++;
            end
            // let the older instructions leave the pipeline
            repeat (6) @(negedge clk);
            check_count({test_name, " store count"}, model_stores, stores_seen);
            check_count({test_name, " load count"}, model_loads, loads_seen);
            if (errors == errors_before) begin
                $display("%s: %0d stores and %0d loads matched", test_name, stores_seen,
                         loads_seen);
            end else begin
                $display("%s: FAILED with %0d errors", test_name, errors - errors_before);
                failed_tests++;
            end
        end
        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the last test finished");
        $display("sim failed");
        $finish;
    end
endmodule

// ==== list.f ====
logic/riscv_isa_pkg.sv
logic/pipe_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/exec_stage.sv
logic/hazard_unit.sv
logic/riscv_pipeline.sv
verification/riscv_pipeline_chk.sv
verification/riscv_pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module riscv_pipeline_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vriscv_pipeline_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
